// File: hdl/bfs_pkg.sv
package bfs_pkg;

  // Graph node address
  typedef logic [31:0] node_addr_t;

  // One cache read beat
  typedef logic [63:0] beat_t;

  // Header beat layout
  localparam int hdr_mark_bit  = 63;
  localparam int hdr_count_lsb = 32;
  localparam int hdr_count_w   = 4;

  typedef logic [hdr_count_w-1:0] neigh_cnt_t;

  // Processor side tags
  typedef logic [6:0] robid_t;
  typedef logic [5:0] rd_t;

  // Search FSM states
  typedef enum logic [2:0] {
    idle,
    init,
    node_header,
    add_neighs,
    report
  } bfs_state_t;

endpackage

// File: hdl/bfs_queue_if.sv
`timescale 1ns/10ps

interface bfs_queue_if import bfs_pkg::*; #(
  parameter int QUEUE_DEPTH = 16
) ();

  localparam int count_w = $clog2(QUEUE_DEPTH + 1);

  // Bit 0 pushes the low word, bit 1 the high word
  logic [1:0]         enq_req;
  beat_t              enq_data;
  logic               deq_req;
  node_addr_t         deq_data;
  logic [count_w-1:0] count;
  logic               full;
  logic               empty;

  // Status decoded from the occupancy count
  assign full  = (count == count_w'(QUEUE_DEPTH));
  assign empty = (count == '0);

  modport core (
    output enq_req, enq_data, deq_req,
    input  deq_data, full, empty
  );

  modport queue (
    input  enq_req, enq_data, deq_req, empty,
    output deq_data, count
  );

endinterface

// File: hdl/bfs_queue.sv
`timescale 1ns/10ps

module bfs_queue import bfs_pkg::*; #(
  parameter int QUEUE_DEPTH = 16
) (
  input logic clk,
  input logic arst_n,
  input logic clr,
  bfs_queue_if.queue q
);

  localparam int ptr_w   = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int count_w = $clog2(QUEUE_DEPTH + 1);

  node_addr_t         mem [QUEUE_DEPTH];
  logic [ptr_w-1:0]   rd_ptr;
  logic [ptr_w-1:0]   wr_ptr;
  logic [count_w-1:0] count_q;
  logic [1:0]         n_enq;
  logic               deq_fire;

  // Wrap works for any depth, not only powers of two
  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
    return (p == ptr_w'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign n_enq    = {1'b0, q.enq_req[0]} + {1'b0, q.enq_req[1]};
  assign deq_fire = q.deq_req & ~q.empty;

  assign q.deq_data = mem[rd_ptr];
  assign q.count    = count_q;

  // Storage, low word goes in first on a double push
  always_ff @(posedge clk) begin
    case (q.enq_req)
      2'b01: mem[wr_ptr] <= q.enq_data[31:0];
      2'b10: mem[wr_ptr] <= q.enq_data[63:32];
      2'b11: begin
        mem[wr_ptr]          <= q.enq_data[31:0];
        mem[ptr_inc(wr_ptr)] <= q.enq_data[63:32];
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_ptr  <= '0;
      wr_ptr  <= '0;
      count_q <= '0;
    end else if (clr) begin
      rd_ptr  <= '0;
      wr_ptr  <= '0;
      count_q <= '0;
    end else begin
      if (n_enq == 2'd2) begin
        wr_ptr <= ptr_inc(ptr_inc(wr_ptr));
      end else if (n_enq == 2'd1) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (deq_fire) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      count_q <= count_q + count_w'(n_enq) - count_w'(deq_fire);
    end
  end

  // Pushes never exceed the free space left after this cycle's pop
  a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
    (|q.enq_req && !clr) |->
      (int'(count_q) + int'(n_enq) - int'(deq_fire) <= QUEUE_DEPTH));

  a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
    q.deq_req |-> !q.empty);

endmodule

// File: hdl/bfs_core.sv
`timescale 1ns/10ps

module bfs_core import bfs_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,

  input  logic       rename_bfs_write,
  input  robid_t     rename_robid,
  input  rd_t        rename_rd,
  input  node_addr_t rename_op1,
  input  node_addr_t rename_op2,
  output logic       bfs_stall,

  output logic       bfs_valid,
  output robid_t     bfs_robid,
  output rd_t        bfs_rd,
  output logic       bfs_result,
  input  logic       wb_bfs_stall,

  output logic       bfs_dc_req,
  output node_addr_t bfs_dc_addr,
  input  logic       dc_ready,
  input  logic       dc_rbuf_empty,
  input  logic       dc_fs,
  input  beat_t      dc_rdata,

  input  logic       rob_flush,
  output logic       q_clr,
  bfs_queue_if.core  q
);

  bfs_state_t state_q;
  bfs_state_t state_d;
  neigh_cnt_t neigh_ct_q;
  neigh_cnt_t neigh_ct_d;
  robid_t     robid_q;
  rd_t        rd_q;
  node_addr_t start_q;
  node_addr_t target_q;
  logic       found_q;
  logic       accept;
  logic       done;
  logic       hdr_marked;
  neigh_cnt_t hdr_count;
  logic       last_neigh_beat;

  assign accept = rename_bfs_write & ~bfs_stall;

  // Command latch
  always_ff @(posedge clk) begin
    if (accept) begin
      robid_q  <= rename_robid;
      rd_q     <= rename_rd;
      start_q  <= rename_op1;
      target_q <= rename_op2;
    end
  end

  // Fetch the queue head whenever the cache can take it
  assign q.deq_req   = ~q.empty & dc_ready;
  assign bfs_dc_req  = q.deq_req;
  assign bfs_dc_addr = q.deq_data;

  assign hdr_marked = dc_rdata[hdr_mark_bit];
  assign hdr_count  = dc_rdata[hdr_count_lsb +: hdr_count_w];

  // One or two neighbors left means this beat is the last
  assign last_neigh_beat = (neigh_ct_q <= neigh_cnt_t'(2));

  // Nothing queued and nothing in flight
  assign done = q.empty & dc_rbuf_empty &
                ((state_q == node_header) | (state_q == add_neighs));

  assign q_clr = done | rob_flush;

  always_comb begin
    state_d    = state_q;
    neigh_ct_d = neigh_ct_q;
    q.enq_req  = 2'b00;
    q.enq_data = dc_rdata;
    case (state_q)
      idle: begin
        if (accept) begin
          state_d = init;
        end
      end
      init: begin
        q.enq_req  = 2'b01;
        q.enq_data = {32'b0, start_q};
        state_d    = node_header;
      end
      node_header: begin
        if (done) begin
          state_d = report;
        end else if (dc_fs && !hdr_marked && hdr_count != '0) begin
          neigh_ct_d = hdr_count;
          state_d    = add_neighs;
        end
      end
      add_neighs: begin
        // High word only when a second neighbor remains
        q.enq_req  = {~last_neigh_beat | (neigh_ct_q == neigh_cnt_t'(2)), 1'b1};
        neigh_ct_d = last_neigh_beat ? '0 : neigh_ct_q - neigh_cnt_t'(2);
        if (done) begin
          state_d = report;
        end else if (last_neigh_beat) begin
          state_d = node_header;
        end
      end
      report: begin
        if (!wb_bfs_stall) begin
          state_d = idle;
        end
      end
      default: state_d = idle;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q    <= idle;
      neigh_ct_q <= '0;
      found_q    <= 1'b0;
    end else if (rob_flush) begin
      state_q    <= idle;
      neigh_ct_q <= '0;
      found_q    <= 1'b0;
    end else begin
      state_q    <= state_d;
      neigh_ct_q <= neigh_ct_d;
      if (state_q == init) begin
        found_q <= 1'b0;
      end else if (q.deq_req && q.deq_data == target_q) begin
        found_q <= 1'b1;
      end
    end
  end

  assign bfs_stall  = (state_q != idle);
  assign bfs_valid  = (state_q == report);
  assign bfs_result = found_q;
  assign bfs_robid  = robid_q;
  assign bfs_rd     = rd_q;

  // Writes during a search never touch the latched command
  a_accept_idle: assert property (@(posedge clk) disable iff (!arst_n)
    (rename_bfs_write && state_q != idle) |=>
      $stable({robid_q, rd_q, start_q, target_q}));

  // Neighbor pushes only land when the queue has room or is draining
  a_enq_room: assert property (@(posedge clk) disable iff (!arst_n)
    (q.enq_req != 2'b00 && q.full && !q_clr) |-> q.deq_req);

endmodule

// File: hdl/bfs_unit.sv
`timescale 1ns/10ps

module bfs_unit import bfs_pkg::*; #(
  parameter int QUEUE_DEPTH = 16
) (
  input  logic       clk,
  input  logic       arst_n,

  input  logic       rename_bfs_write,
  input  robid_t     rename_robid,
  input  rd_t        rename_rd,
  input  node_addr_t rename_op1,
  input  node_addr_t rename_op2,
  output logic       bfs_stall,

  output logic       bfs_valid,
  output robid_t     bfs_robid,
  output rd_t        bfs_rd,
  output logic       bfs_result,
  input  logic       wb_bfs_stall,

  output logic       bfs_dc_req,
  output node_addr_t bfs_dc_addr,
  input  logic       dc_ready,
  input  logic       dc_rbuf_empty,
  input  logic       dc_fs,
  input  beat_t      dc_rdata,

  input  logic       rob_flush
);

  logic q_clr;

  bfs_queue_if #(.QUEUE_DEPTH(QUEUE_DEPTH)) q_if ();

  bfs_core i_core (
    .clk              (clk),
    .arst_n           (arst_n),
    .rename_bfs_write (rename_bfs_write),
    .rename_robid     (rename_robid),
    .rename_rd        (rename_rd),
    .rename_op1       (rename_op1),
    .rename_op2       (rename_op2),
    .bfs_stall        (bfs_stall),
    .bfs_valid        (bfs_valid),
    .bfs_robid        (bfs_robid),
    .bfs_rd           (bfs_rd),
    .bfs_result       (bfs_result),
    .wb_bfs_stall     (wb_bfs_stall),
    .bfs_dc_req       (bfs_dc_req),
    .bfs_dc_addr      (bfs_dc_addr),
    .dc_ready         (dc_ready),
    .dc_rbuf_empty    (dc_rbuf_empty),
    .dc_fs            (dc_fs),
    .dc_rdata         (dc_rdata),
    .rob_flush        (rob_flush),
    .q_clr            (q_clr),
    .q                (q_if.core)
  );

  bfs_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_queue (
    .clk    (clk),
    .arst_n (arst_n),
    .clr    (q_clr),
    .q      (q_if.queue)
  );

endmodule

// File: sim/graph_mem_model.sv
`timescale 1ns/10ps

module graph_mem_model import bfs_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       clear_marks,
  input  logic       dc_req,
  input  node_addr_t dc_addr,
  output logic       dc_ready,
  output logic       dc_rbuf_empty,
  output logic       dc_fs,
  output beat_t      dc_rdata
);

  localparam logic [31:0] lfsr_seed = 32'h61ff8889;

  // Up to three neighbors per node, addresses at 0x1000 + 16*index
  node_addr_t  adj [16][3];
  int          deg [16];
  logic [15:0] marks;
  logic [31:0] lfsr;

  // Beats in flight, one leaves per cycle
  beat_t       beat_buf [64];
  logic        fs_buf [64];
  logic [5:0]  head;
  logic [5:0]  tail;
  int          cnt;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic node_addr_t node_addr(input int i);
    return 32'h1000 + 32'(i) * 32'd16;
  endfunction

  initial begin
    for (int i = 0; i < 16; i++) begin
      deg[i] = 0;
    end
    // Component of nodes 0 to 6, node 2 and node 5 lead back to the start
    adj[0][0] = node_addr(1); adj[0][1] = node_addr(2); adj[0][2] = node_addr(3); deg[0] = 3;
    adj[1][0] = node_addr(4); adj[1][1] = node_addr(5); deg[1] = 2;
    adj[2][0] = node_addr(0); deg[2] = 1;
    adj[3][0] = node_addr(6); deg[3] = 1;
    adj[4][0] = node_addr(6); adj[4][1] = node_addr(2); adj[4][2] = node_addr(1); deg[4] = 3;
    adj[5][0] = node_addr(0); deg[5] = 1;
    adj[6][0] = node_addr(5); deg[6] = 1;
    // Isolated pair
    adj[7][0] = node_addr(8); deg[7] = 1;
    adj[8][0] = node_addr(7); deg[8] = 1;
    // Node 9 has no neighbors
  end

  assign dc_rdata      = beat_buf[head];
  assign dc_fs         = (cnt != 0) && fs_buf[head];
  assign dc_rbuf_empty = (cnt == 0) && !dc_req;

  always @(posedge clk or negedge arst_n) begin
    logic [31:0] s;
    logic        b0;
    logic        b1;
    logic [5:0]  t;
    int          n;
    int          idx;
    beat_t       hdr;
    if (!arst_n) begin
      head     <= '0;
      tail     <= '0;
      cnt      <= 0;
      marks    <= '0;
      lfsr     <= lfsr_seed;
      dc_ready <= 1'b0;
    end else begin
      // Two bits per cycle, ready unless both are zero
      s  = lfsr;
      b0 = s[0];
      s  = lfsr_step(s);
      b1 = s[0];
      s  = lfsr_step(s);
      lfsr     <= s;
      dc_ready <= b0 | b1;

      t = tail;
      n = cnt;
      if (cnt != 0) begin
        head <= head + 6'd1;
        n = n - 1;
      end
      if (clear_marks) begin
        marks <= '0;
      end
      if (dc_req) begin
        idx = int'(dc_addr[7:4]);
        hdr = '0;
        hdr[hdr_mark_bit] = marks[idx];
        hdr[hdr_count_lsb +: hdr_count_w] = neigh_cnt_t'(deg[idx]);
        hdr[31:0] = dc_addr;
        beat_buf[t] <= hdr;
        fs_buf[t]   <= 1'b1;
        t = t + 6'd1;
        n = n + 1;
        for (int k = 0; k < deg[idx]; k += 2) begin
          beat_buf[t] <= {(k + 1 < deg[idx]) ? adj[idx][k + 1] : 32'h0, adj[idx][k]};
          fs_buf[t]   <= 1'b0;
          t = t + 6'd1;
          n = n + 1;
        end
        marks[idx] <= 1'b1;
      end
      tail <= t;
      cnt  <= n;
    end
  end

endmodule

// File: sim/tb_bfs_unit.sv
`timescale 1ns/10ps

module tb_bfs_unit import bfs_pkg::*; ();

  localparam int wait_limit = 2000;

  logic       clk = 1'b0;
  logic       arst_n;
  logic       rename_bfs_write;
  robid_t     rename_robid;
  rd_t        rename_rd;
  node_addr_t rename_op1;
  node_addr_t rename_op2;
  logic       bfs_stall;
  logic       bfs_valid;
  robid_t     bfs_robid;
  rd_t        bfs_rd;
  logic       bfs_result;
  logic       wb_bfs_stall;
  logic       bfs_dc_req;
  node_addr_t bfs_dc_addr;
  logic       dc_ready;
  logic       dc_rbuf_empty;
  logic       dc_fs;
  beat_t      dc_rdata;
  logic       rob_flush;
  logic       clear_marks;

  // Expected response of the command in flight
  logic       exp_result;
  robid_t     exp_robid;
  rd_t        exp_rd;
  node_addr_t exp_start;
  logic       first_fetch = 1'b0;
  logic       flushed;
  int         assert_errors = 0;
  int         timeouts = 0;

  always #4 clk = ~clk;

  bfs_unit #(.QUEUE_DEPTH(16)) i_dut (
    .clk(clk), .arst_n(arst_n),
    .rename_bfs_write(rename_bfs_write), .rename_robid(rename_robid),
    .rename_rd(rename_rd), .rename_op1(rename_op1), .rename_op2(rename_op2),
    .bfs_stall(bfs_stall), .bfs_valid(bfs_valid), .bfs_robid(bfs_robid),
    .bfs_rd(bfs_rd), .bfs_result(bfs_result), .wb_bfs_stall(wb_bfs_stall),
    .bfs_dc_req(bfs_dc_req), .bfs_dc_addr(bfs_dc_addr), .dc_ready(dc_ready),
    .dc_rbuf_empty(dc_rbuf_empty), .dc_fs(dc_fs), .dc_rdata(dc_rdata),
    .rob_flush(rob_flush)
  );

  graph_mem_model i_mem (
    .clk(clk), .arst_n(arst_n), .clear_marks(clear_marks),
    .dc_req(bfs_dc_req), .dc_addr(bfs_dc_addr), .dc_ready(dc_ready),
    .dc_rbuf_empty(dc_rbuf_empty), .dc_fs(dc_fs), .dc_rdata(dc_rdata)
  );

  function automatic void count_failure(input string msg);
    assert_errors = assert_errors + 1;
    $display("FAILED %0t: %s", $time, msg);
  endfunction

  // Set on acceptance, cleared by the first cache fetch
  always @(posedge clk) begin
    if (rename_bfs_write && !bfs_stall) begin
      first_fetch <= 1'b1;
    end else if (bfs_dc_req) begin
      first_fetch <= 1'b0;
    end
  end

  a_reset: assert property (@(posedge clk)
    $rose(arst_n) |-> (!bfs_valid && !bfs_stall && !bfs_dc_req))
    else count_failure("outputs active after reset");
  a_req_ready: assert property (@(posedge clk) disable iff (!arst_n)
    bfs_dc_req |-> dc_ready)
    else count_failure("cache request without dc_ready");
  a_first_fetch: assert property (@(posedge clk) disable iff (!arst_n)
    (first_fetch && bfs_dc_req) |-> (bfs_dc_addr == exp_start))
    else count_failure("first cache fetch is not the start node");
  a_result: assert property (@(posedge clk) disable iff (!arst_n)
    bfs_valid |-> (bfs_result == exp_result))
    else count_failure($sformatf("bfs_result %0b expected %0b",
                                 bfs_result, exp_result));
  a_tags: assert property (@(posedge clk) disable iff (!arst_n)
    bfs_valid |-> (bfs_robid == exp_robid && bfs_rd == exp_rd))
    else count_failure("writeback tags differ from command");
  a_accept: assert property (@(posedge clk) disable iff (!arst_n)
    (rename_bfs_write && !bfs_stall && !rob_flush) |=> bfs_stall)
    else count_failure("bfs_stall low after accept");
  a_busy: assert property (@(posedge clk) disable iff (!arst_n)
    (bfs_stall && !bfs_valid && !rob_flush) |=> bfs_stall)
    else count_failure("bfs_stall fell during search");
  a_ignore: assert property (@(posedge clk) disable iff (!arst_n)
    (rename_bfs_write && bfs_stall) |=> ($stable(bfs_robid) && $stable(bfs_rd)))
    else count_failure("stalled command changed tags");
  a_hold: assert property (@(posedge clk) disable iff (!arst_n)
    (bfs_valid && wb_bfs_stall && !rob_flush) |=> (bfs_valid && $stable(bfs_result)))
    else count_failure("result not held under stall");
  a_release: assert property (@(posedge clk) disable iff (!arst_n)
    (bfs_valid && !wb_bfs_stall && !rob_flush) |=> (!bfs_valid && !bfs_stall))
    else count_failure("core not idle after writeback");
  a_flush: assert property (@(posedge clk) disable iff (!arst_n)
    rob_flush |=> (!bfs_valid && !bfs_stall))
    else count_failure("flush did not stop the core");
  a_flush_quiet: assert property (@(posedge clk) disable iff (!arst_n)
    flushed |-> !bfs_valid)
    else count_failure("bfs_valid after flush");

  function automatic node_addr_t node_addr(input int i);
    return 32'h1000 + 32'(i) * 32'd16;
  endfunction

  task automatic wait_cache_idle();
    int n;
    n = 0;
    @(negedge clk);
    while (!(dc_rbuf_empty && !bfs_stall) && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (!(dc_rbuf_empty && !bfs_stall)) begin
      timeouts++;
      $display("Timeout at %0t: core and cache never went idle", $time);
    end
  endtask

  task automatic send_command(input int start, input int target, input logic exp,
                              input robid_t robid, input rd_t rd, input int hold);
    @(posedge clk);
    clear_marks <= 1'b1;
    flushed     <= 1'b0;
    @(posedge clk);
    clear_marks      <= 1'b0;
    rename_bfs_write <= 1'b1;
    rename_robid     <= robid;
    rename_rd        <= rd;
    rename_op1       <= node_addr(start);
    rename_op2       <= node_addr(target);
    exp_result       <= exp;
    exp_robid        <= robid;
    exp_rd           <= rd;
    exp_start        <= node_addr(start);
    wb_bfs_stall     <= (hold > 0);
    // Keep writing while stalled but with other tags
    @(posedge clk);
    rename_robid <= ~robid;
    rename_rd    <= ~rd;
    rename_op1   <= node_addr(9);
    rename_op2   <= node_addr(0);
    @(posedge clk);
    rename_bfs_write <= 1'b0;
  endtask

  task automatic await_result(input int hold);
    int n;
    n = 0;
    @(negedge clk);
    while (!bfs_valid && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (!bfs_valid) begin
      timeouts++;
      $display("Timeout at %0t: no result from the search", $time);
    end
    if (hold > 0) begin
      repeat (hold) @(posedge clk);
      wb_bfs_stall <= 1'b0;
    end
    n = 0;
    @(negedge clk);
    while (bfs_valid && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (bfs_valid) begin
      timeouts++;
      $display("Timeout at %0t: writeback never completed", $time);
    end
  endtask

  task automatic check_search(input int start, input int target, input logic exp,
                              input robid_t robid, input rd_t rd, input int hold);
    wait_cache_idle();
    send_command(start, target, exp, robid, rd, hold);
    await_result(hold);
  endtask

  initial begin
    arst_n           = 1'b0;
    rename_bfs_write = 1'b0;
    rename_robid     = '0;
    rename_rd        = '0;
    rename_op1       = '0;
    rename_op2       = '0;
    wb_bfs_stall     = 1'b0;
    rob_flush        = 1'b0;
    clear_marks      = 1'b0;
    exp_result       = 1'b0;
    exp_robid        = '0;
    exp_rd           = '0;
    exp_start        = '0;
    flushed          = 1'b0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;

    check_search(0, 6, 1'b1, 7'h11, 6'h01, 0);
    check_search(2, 4, 1'b1, 7'h22, 6'h02, 2);
    check_search(0, 8, 1'b0, 7'h33, 6'h03, 0);
    check_search(9, 0, 1'b0, 7'h44, 6'h04, 1);
    check_search(7, 8, 1'b1, 7'h55, 6'h05, 0);

    // Flush in the middle of a search
    wait_cache_idle();
    send_command(0, 5, 1'b1, 7'h66, 6'h06, 0);
    repeat (5) @(posedge clk);
    rob_flush <= 1'b1;
    @(posedge clk);
    rob_flush <= 1'b0;
    flushed   <= 1'b1;
    repeat (10) @(posedge clk);
    check_search(4, 3, 1'b1, 7'h77, 6'h07, 3);

    repeat (4) @(posedge clk);
    $display("Errors: %0d assertion failures, %0d timeouts", assert_errors, timeouts);
    if (assert_errors == 0 && timeouts == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
hdl/bfs_pkg.sv
hdl/bfs_queue_if.sv
hdl/bfs_queue.sv
hdl/bfs_core.sv
hdl/bfs_unit.sv
sim/graph_mem_model.sv
sim/tb_bfs_unit.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the BFS unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_bfs_unit -o tb_bfs_unit
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/tb_bfs_unit)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

if grep -qx "Simulation passed" <<< "$output"; then
  exit 0
else
  exit 1
fi
